// ==== common/sw_fdb_pkg.sv ====
// forwarding table entry types and the decoded wishbone data word
`default_nettype none

`include "sw_params.svh"

package sw_fdb_pkg;

   // upper half of an entry as seen at odd wishbone addresses
   typedef struct packed {
      logic                               valid;
      sw_frame_pkg::port_t                port;
      logic [14-sw_frame_pkg::PORT_W:0]   rsvd;    // reads back as zero
      logic [15:0]                        mac_hi;  // mac bits 47..32
   } fdb_hi_t;

   // one bus word, view picked by address bit 0
   typedef union packed {
      sw_frame_pkg::word_t mac_lo;  // even address, mac bits 31..0
      fdb_hi_t             hi;      // odd address
   } fdb_wdata_u;

   // stored entry
   typedef struct packed {
      logic                valid;
      sw_frame_pkg::port_t port;
      sw_frame_pkg::mac_t  mac;
   } fdb_entry_t;

endpackage

`default_nettype wire

// ==== common/sw_frame_pkg.sv ====
// frame traffic types shared by the port, fabric and table blocks
`default_nettype none

`include "sw_params.svh"

package sw_frame_pkg;

   localparam int PORT_W = $clog2(`SW_NUM_PORTS);

   // one data path word, byte 0 in the low bits
   typedef logic [`SW_WORD_W-1:0] word_t;

   // mac address as captured from frame bytes 0..5
   typedef logic [47:0] mac_t;

   typedef logic [PORT_W-1:0] port_t;  // index into the port arrays

endpackage

`default_nettype wire

// ==== common/sw_params.svh ====
// switch size macros, included by the packages, the RTL and the testbench
`ifndef SW_PARAMS_SVH
`define SW_PARAMS_SVH

// number of switch ports, also valid at 2, 6 or 8
`define SW_NUM_PORTS 4

// data path word, filled from 8 nibbles
`define SW_WORD_W 32

// ingress buffer depth, room for two maximum frames
`define SW_BUF_WORDS 32

`define SW_MAX_FRAME_WORDS 16

// forwarding table size, addressed by wishbone bits 3..1
`define SW_FDB_ENTRIES 8

`endif

// ==== fabric/fdb_table.sv ====
// forwarding table: wishbone writes and readback, one combinational lookup per port
`default_nettype none

`include "sw_params.svh"

module fdb_table (
   input  logic                                      clk,
   input  logic                                      reset_i,
   input  logic                                      wb_cyc_i,
   input  logic                                      wb_stb_i,
   input  logic                                      wb_we_i,
   input  logic [$clog2(`SW_FDB_ENTRIES):0]          wb_adr_i,
   input  sw_frame_pkg::word_t                       wb_dat_i,
   input  sw_frame_pkg::mac_t [`SW_NUM_PORTS-1:0]    lookup_mac_i,
   output sw_frame_pkg::word_t                       wb_dat_o,
   output logic                                      wb_ack_o,
   output logic [`SW_NUM_PORTS-1:0]                  lookup_hit_o,
   output sw_frame_pkg::port_t [`SW_NUM_PORTS-1:0]   lookup_port_o
);

   localparam int IDX_W = $clog2(`SW_FDB_ENTRIES);

   sw_fdb_pkg::fdb_entry_t tbl [`SW_FDB_ENTRIES];
   sw_fdb_pkg::fdb_wdata_u wd;
   sw_fdb_pkg::fdb_wdata_u rd;
   logic [IDX_W-1:0]       entry_sel;
   logic                   access;

   assign wd        = wb_dat_i;
   assign entry_sel = wb_adr_i[IDX_W:1];
   assign access    = wb_cyc_i && wb_stb_i && !wb_ack_o;   // one ack per request

   always_comb
   begin
      rd = '0;
      if (wb_adr_i[0])
      begin
         rd.hi.valid  = tbl[entry_sel].valid;
         rd.hi.port   = tbl[entry_sel].port;
         rd.hi.mac_hi = tbl[entry_sel].mac[47:32];
      end
      else
         rd.mac_lo = tbl[entry_sel].mac[31:0];
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         wb_ack_o <= 1'b0;
         for (int k = 0; k < `SW_FDB_ENTRIES; k++)
            tbl[k] <= '0;
      end
      else
      begin
         wb_ack_o <= access;
         if (access && wb_we_i)
         begin
            if (wb_adr_i[0])
            begin
               tbl[entry_sel].valid      <= wd.hi.valid;
               tbl[entry_sel].port       <= wd.hi.port;
               tbl[entry_sel].mac[47:32] <= wd.hi.mac_hi;
            end
            else
               tbl[entry_sel].mac[31:0] <= wd.mac_lo;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (access)
         wb_dat_o <= rd;
   end

   // scan from the top so the lowest matching entry wins
   always_comb
   begin
      for (int p = 0; p < `SW_NUM_PORTS; p++)
      begin
         lookup_hit_o[p]  = 1'b0;
         lookup_port_o[p] = '0;
         for (int k = `SW_FDB_ENTRIES - 1; k >= 0; k--)
         begin
            if (tbl[k].valid && tbl[k].mac == lookup_mac_i[p])
            begin
               lookup_hit_o[p]  = 1'b1;
               lookup_port_o[p] = tbl[k].port;
            end
         end
      end
   end

   // the master drops stb after seeing ack
   assert property (@(posedge clk) disable iff (reset_i) wb_ack_o |=> !wb_stb_i);

endmodule

`default_nettype wire

// ==== fabric/xbar_arbiter.sv ====
// word crossbar: round-robin grant per egress port, held to the last word, and frame discard
`default_nettype none

`include "sw_params.svh"

module xbar_arbiter (
   input  logic                                    clk,
   input  logic                                    reset_i,
   input  logic [`SW_NUM_PORTS-1:0]                frame_rdy_i,
   input  logic [`SW_NUM_PORTS-1:0]                lookup_hit_i,
   input  sw_frame_pkg::port_t [`SW_NUM_PORTS-1:0] lookup_port_i,
   input  sw_frame_pkg::word_t [`SW_NUM_PORTS-1:0] head_word_i,
   input  logic [`SW_NUM_PORTS-1:0]                head_last_i,
   input  logic [`SW_NUM_PORTS-1:0]                tx_ready_i,
   output logic [`SW_NUM_PORTS-1:0]                pop_o,
   output sw_frame_pkg::word_t [`SW_NUM_PORTS-1:0] tx_word_o,
   output logic [`SW_NUM_PORTS-1:0]                tx_valid_o,
   output logic [`SW_NUM_PORTS-1:0]                tx_last_o
);

   localparam int N = `SW_NUM_PORTS;

   logic [N-1:0]                lock_q;    // egress holds a grant
   sw_frame_pkg::port_t [N-1:0] src_q;
   sw_frame_pkg::port_t [N-1:0] rr_q;      // last granted ingress
   logic [N-1:0]                disc_q;    // ingress mid-discard
   logic [N-1:0]                fwd_ok;
   logic [N-1:0]                in_busy;
   logic [N-1:0]                disc_act;
   logic [N-1:0]                new_any;
   logic [N-1:0]                new_gnt;
   logic [N-1:0]                act;
   sw_frame_pkg::port_t [N-1:0] new_src;
   sw_frame_pkg::port_t [N-1:0] sel;

   // ingress side: forward or throw away
   always_comb
   begin
      for (int i = 0; i < N; i++)
      begin
         fwd_ok[i]  = lookup_hit_i[i] && (lookup_port_i[i] != sw_frame_pkg::port_t'(i));
         in_busy[i] = 1'b0;
         for (int e = 0; e < N; e++)
         begin
            if (lock_q[e] && src_q[e] == sw_frame_pkg::port_t'(i))
               in_busy[i] = 1'b1;
         end
         disc_act[i] = disc_q[i] || (frame_rdy_i[i] && !in_busy[i] && !fwd_ok[i]);
      end
   end

   always_comb
   begin
      int idx;
      for (int e = 0; e < N; e++)
      begin
         new_any[e] = 1'b0;
         new_src[e] = rr_q[e];
         for (int k = 1; k <= N; k++)
         begin
            idx = (int'(rr_q[e]) + k) % N;
            if (!new_any[e] && frame_rdy_i[idx] && fwd_ok[idx] && !in_busy[idx]
                && !disc_q[idx] && lookup_port_i[idx] == sw_frame_pkg::port_t'(e))
            begin
               new_any[e] = 1'b1;
               new_src[e] = sw_frame_pkg::port_t'(idx);
            end
         end
         new_gnt[e] = !lock_q[e] && tx_ready_i[e] && new_any[e];   // first word moves now
         sel[e]     = lock_q[e] ? src_q[e] : new_src[e];
         act[e]     = lock_q[e] || new_gnt[e];
      end
   end

   always_comb
   begin
      pop_o = disc_act;   // discard drains a word per cycle
      for (int e = 0; e < N; e++)
      begin
         tx_valid_o[e] = act[e];
         tx_word_o[e]  = head_word_i[sel[e]];
         tx_last_o[e]  = head_last_i[sel[e]];
         if (act[e] && tx_ready_i[e])
            pop_o[sel[e]] = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         lock_q <= '0;
         disc_q <= '0;
         for (int e = 0; e < N; e++)
         begin
            src_q[e] <= '0;
            rr_q[e]  <= sw_frame_pkg::port_t'(N - 1);   // port 0 first
         end
      end
      else
      begin
         for (int i = 0; i < N; i++)
         begin
            if (disc_act[i])
               disc_q[i] <= !head_last_i[i];
         end
         for (int e = 0; e < N; e++)
         begin
            if (act[e] && tx_ready_i[e])
            begin
               lock_q[e] <= !head_last_i[sel[e]];
               src_q[e]  <= sel[e];
            end
            if (new_gnt[e])
               rr_q[e] <= new_src[e];
         end
      end
   end

   for (genvar i = 0; i < N; i++)
   begin : g_chk
      logic [N-1:0] hold;

      always_comb
      begin
         for (int e = 0; e < N; e++)
            hold[e] = act[e] && sel[e] == sw_frame_pkg::port_t'(i);
      end

      // one ingress buffer feeds at most one egress
      assert property (@(posedge clk) disable iff (reset_i) $onehot0(hold));
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/sw_frame_pkg.sv
common/sw_fdb_pkg.sv
port/port_rx.sv
port/port_tx.sv
fabric/fdb_table.sv
fabric/xbar_arbiter.sv
src/switch_top.sv
test/switch_tb.sv

// ==== port/port_rx.sv ====
// ingress side of one port: nibbles to words, frame buffer and destination mac queue
`default_nettype none

`include "sw_params.svh"

module port_rx (
   input  logic                clk,
   input  logic                reset_i,
   input  logic [3:0]          rx_nibble_i,
   input  logic                rx_dv_i,
   input  logic                pop_i,
   output logic                frame_rdy_o,
   output sw_frame_pkg::mac_t  dest_mac_o,
   output sw_frame_pkg::word_t head_word_o,
   output logic                head_last_o
);

   localparam int AW = $clog2(`SW_BUF_WORDS);
   localparam int FW = AW + 1;
   localparam int CW = $clog2(`SW_MAX_FRAME_WORDS) + 1;
   localparam int NW = `SW_WORD_W / 4;

   sw_frame_pkg::word_t          buf_mem [`SW_BUF_WORDS];
   logic [`SW_BUF_WORDS-1:0]     last_mem;
   logic [AW-1:0]                wr_ptr;
   logic [AW-1:0]                rd_ptr;
   logic [FW-1:0]                fill;
   sw_frame_pkg::word_t          shift_q;
   logic [$clog2(NW)-1:0]        nib_cnt;
   logic [CW-1:0]                word_cnt;   // words so far in this frame
   logic                         dv_q;
   sw_frame_pkg::word_t          mac_lo_q;
   logic [15:0]                  mac_hi_q;
   sw_frame_pkg::mac_t           desc_q [2];
   logic                         desc_wp;
   logic                         desc_rp;
   logic [1:0]                   frame_cnt;
   logic                         word_done;
   logic                         frame_end;
   logic                         pop_last;
   sw_frame_pkg::word_t          word_new;

   // low nibble first, so new nibbles enter at the top
   assign word_new  = {rx_nibble_i, shift_q[`SW_WORD_W-1:4]};
   assign word_done = rx_dv_i && (nib_cnt == $bits(nib_cnt)'(NW - 1));
   assign frame_end = dv_q && !rx_dv_i;
   assign pop_last  = pop_i && head_last_o;

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         nib_cnt  <= '0;
         word_cnt <= '0;
         dv_q     <= 1'b0;
      end
      else
      begin
         dv_q <= rx_dv_i;
         if (!rx_dv_i)
         begin
            nib_cnt  <= '0;
            word_cnt <= '0;
         end
         else
         begin
            nib_cnt <= nib_cnt + 1'b1;
            if (word_done)
               word_cnt <= word_cnt + 1'b1;
         end
      end
   end

   // destination is bytes 0..5
   always_ff @(posedge clk)
   begin
      if (rx_dv_i)
         shift_q <= word_new;
      if (word_done && word_cnt == '0)
         mac_lo_q <= word_new;
      if (word_done && word_cnt == CW'(1))
         mac_hi_q <= word_new[15:0];
      if (frame_end)
         desc_q[desc_wp] <= {mac_hi_q, mac_lo_q};
   end

   // the last flag is patched in once dv has dropped
   always_ff @(posedge clk)
   begin
      if (word_done)
      begin
         buf_mem[wr_ptr]  <= word_new;
         last_mem[wr_ptr] <= 1'b0;
      end
      if (frame_end)
         last_mem[wr_ptr - 1'b1] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         frame_cnt <= '0;
         desc_wp   <= 1'b0;
         desc_rp   <= 1'b0;
      end
      else
      begin
         if (word_done)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
         fill      <= fill + FW'(word_done) - FW'(pop_i);
         frame_cnt <= frame_cnt + 2'(frame_end) - 2'(pop_last);
         if (frame_end)
            desc_wp <= !desc_wp;
         if (pop_last)
            desc_rp <= !desc_rp;   // next frame's mac shows up
      end
   end

   assign frame_rdy_o = (frame_cnt != '0);
   assign dest_mac_o  = desc_q[desc_rp];
   assign head_word_o = buf_mem[rd_ptr];
   assign head_last_o = last_mem[rd_ptr];

   // the fabric must drain before a third frame arrives
   assert property (@(posedge clk) disable iff (reset_i)
      word_done && !pop_i |-> fill != FW'(`SW_BUF_WORDS));

   assert property (@(posedge clk) disable iff (reset_i) pop_i |-> fill != '0);

endmodule

`default_nettype wire

// ==== port/port_tx.sv ====
// egress side of one port: sends words out as nibbles, one word per 8 cycles
`default_nettype none

`include "sw_params.svh"

module port_tx (
   input  logic                clk,
   input  logic                reset_i,
   input  sw_frame_pkg::word_t word_i,
   input  logic                word_valid_i,
   input  logic                word_last_i,
   output logic                ready_o,
   output logic [3:0]          tx_nibble_o,
   output logic                tx_en_o
);

   localparam int NW = `SW_WORD_W / 4;

   sw_frame_pkg::word_t   sh_q;
   logic [$clog2(NW)-1:0] cnt_q;
   logic                  busy_q;
   logic                  last_q;    // word in flight ends the frame
   logic                  accept;

   // next word taken during the final nibble, except after the last word
   assign ready_o = !busy_q || (cnt_q == $bits(cnt_q)'(NW - 1) && !last_q);
   assign accept  = word_valid_i && ready_o;

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         last_q <= 1'b0;
      end
      else if (accept)
      begin
         busy_q <= 1'b1;
         cnt_q  <= '0;
         last_q <= word_last_i;
      end
      else if (busy_q)
      begin
         cnt_q <= cnt_q + 1'b1;
         if (cnt_q == $bits(cnt_q)'(NW - 1))
            busy_q <= 1'b0;   // gap cycle after the frame
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         sh_q <= word_i;
      else if (busy_q)
         sh_q <= {4'b0, sh_q[`SW_WORD_W-1:4]};
   end

   assign tx_nibble_o = sh_q[3:0];
   assign tx_en_o     = busy_q;

   // an offered word is held by the fabric until it is taken
   assert property (@(posedge clk) disable iff (reset_i)
      word_valid_i && !ready_o |=> word_valid_i && $stable(word_i));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module switch_tb -f flist.f \
   -o switch_sim > build.log 2>&1 &&
   ./obj_dir/switch_sim > sim.log 2>&1 ||
   echo "build or simulation error, Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// ==== src/switch_top.sv ====
// switch top level, wires the ports, forwarding table and crossbar together
`default_nettype none

`include "sw_params.svh"

module switch_top (
   input  logic                                clk,
   input  logic                                reset_i,
   input  logic [`SW_NUM_PORTS-1:0][3:0]       rx_nibble_i,
   input  logic [`SW_NUM_PORTS-1:0]            rx_dv_i,
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   input  logic                                wb_we_i,
   input  logic [$clog2(`SW_FDB_ENTRIES):0]    wb_adr_i,
   input  sw_frame_pkg::word_t                 wb_dat_i,
   output logic [`SW_NUM_PORTS-1:0][3:0]       tx_nibble_o,
   output logic [`SW_NUM_PORTS-1:0]            tx_en_o,
   output sw_frame_pkg::word_t                 wb_dat_o,
   output logic                                wb_ack_o
);

   localparam int N = `SW_NUM_PORTS;

   logic [N-1:0]                frame_rdy;
   sw_frame_pkg::mac_t [N-1:0]  dest_mac;
   sw_frame_pkg::word_t [N-1:0] head_word;
   logic [N-1:0]                head_last;
   logic [N-1:0]                pop;
   logic [N-1:0]                hit;
   sw_frame_pkg::port_t [N-1:0] hit_port;
   sw_frame_pkg::word_t [N-1:0] xb_word;
   logic [N-1:0]                xb_valid;
   logic [N-1:0]                xb_last;
   logic [N-1:0]                tx_ready;

   for (genvar p = 0; p < N; p++)
   begin : g_port
      port_rx u_rx (
         .clk         (clk),
         .reset_i     (reset_i),
         .rx_nibble_i (rx_nibble_i[p]),
         .rx_dv_i     (rx_dv_i[p]),
         .pop_i       (pop[p]),
         .frame_rdy_o (frame_rdy[p]),
         .dest_mac_o  (dest_mac[p]),
         .head_word_o (head_word[p]),
         .head_last_o (head_last[p])
      );

      port_tx u_tx (
         .clk          (clk),
         .reset_i      (reset_i),
         .word_i       (xb_word[p]),
         .word_valid_i (xb_valid[p]),
         .word_last_i  (xb_last[p]),
         .ready_o      (tx_ready[p]),
         .tx_nibble_o  (tx_nibble_o[p]),
         .tx_en_o      (tx_en_o[p])
      );
   end

   fdb_table u_fdb (
      .clk           (clk),
      .reset_i       (reset_i),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .lookup_mac_i  (dest_mac),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o),
      .lookup_hit_o  (hit),
      .lookup_port_o (hit_port)
   );

   xbar_arbiter u_xbar (
      .clk           (clk),
      .reset_i       (reset_i),
      .frame_rdy_i   (frame_rdy),
      .lookup_hit_i  (hit),
      .lookup_port_i (hit_port),
      .head_word_i   (head_word),
      .head_last_i   (head_last),
      .tx_ready_i    (tx_ready),
      .pop_o         (pop),
      .tx_word_o     (xb_word),
      .tx_valid_o    (xb_valid),
      .tx_last_o     (xb_last)
   );

endmodule

`default_nettype wire

// ==== test/switch_tb.sv ====
// switch testbench, runs the table accesses and frames listed in test/switch_vectors.txt
`default_nettype none

`include "sw_params.svh"

module switch_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N       = `SW_NUM_PORTS;
   localparam int MAX_FRM = 64;
   localparam int MAX_CMD = 256;

   logic                             clk;
   logic                             reset_i;
   wire  [N-1:0][3:0]                rx_nibble_i;
   wire  [N-1:0]                     rx_dv_i;
   logic                             wb_cyc_i;
   logic                             wb_stb_i;
   logic                             wb_we_i;
   logic [$clog2(`SW_FDB_ENTRIES):0] wb_adr_i;
   sw_frame_pkg::word_t              wb_dat_i;
   logic [N-1:0][3:0]                tx_nibble_o;
   logic [N-1:0]                     tx_en_o;
   sw_frame_pkg::word_t              wb_dat_o;
   logic                             wb_ack_o;

   int                     frm_src [MAX_FRM];
   int                     frm_len [MAX_FRM];
   sw_frame_pkg::word_t    frm_word [MAX_FRM][`SW_MAX_FRAME_WORDS];
   sw_frame_pkg::port_t    frm_dst [MAX_FRM];
   logic                   frm_drop [MAX_FRM];
   logic                   frm_seen [MAX_FRM];
   int                     n_frm = 0;
   byte                    cmd_kind [MAX_CMD];
   int                     cmd_a [MAX_CMD];
   sw_frame_pkg::word_t    cmd_b [MAX_CMD];
   int                     n_cmd = 0;
   int                     nibbles = 0;
   sw_fdb_pkg::fdb_entry_t model [`SW_FDB_ENTRIES];   // expected table contents
   int                     send_q [N][$];
   int                     exp_q [N][N][$];             // [egress][ingress] frame ids
   sw_frame_pkg::word_t    got_q [N][$];
   sw_frame_pkg::word_t    mon_word [N];
   int                     mon_nib [N] = '{default: 0};
   logic [N-1:0]           mon_en_q = '0;
   wire  [N-1:0]           drv_busy;
   int                     cycles = 0;
   int                     limit = 0;
   int                     errors = 0;
   int                     tests = 0;
   int                     failed = 0;

   switch_top DUT (
      .clk         (clk),
      .reset_i     (reset_i),
      .rx_nibble_i (rx_nibble_i),
      .rx_dv_i     (rx_dv_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .tx_nibble_o (tx_nibble_o),
      .tx_en_o     (tx_en_o),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("timeout: traffic still pending after %0d cycles", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic check_word(sw_frame_pkg::word_t got, sw_frame_pkg::word_t exp, string what);
      if (got !== exp)
      begin
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_port(sw_frame_pkg::port_t got, sw_frame_pkg::port_t exp, string what);
      if (got !== exp)
      begin
         $display("FAIL %0t: %s is port %0d, expected port %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic close_test(string name, int err0);
      tests++;
      if (errors == err0)
         $display("%s: ok", name);
      else
      begin
         failed++;
         $display("%s: error", name);
      end
   endtask

   task automatic read_vectors(output logic ok);
      int fd;
      int c;
      int n;
      int a;
      int len;
      sw_frame_pkg::word_t v;
      ok = 1'b1;
      fd = $fopen("test/switch_vectors.txt", "r");
      if (fd == 0)
         ok = 1'b0;
      else
      begin
         c = $fgetc(fd);
         while (c != -1)
         begin
            if (c == "#")
            begin
               while (c != "\n" && c != -1)
                  c = $fgetc(fd);
            end
            else if (c == "W" || c == "R")
            begin
               n = $fscanf(fd, "%h %h", a, v);
               if (n != 2)
                  ok = 1'b0;
               cmd_kind[n_cmd] = 8'(c);
               cmd_a[n_cmd]    = a;
               cmd_b[n_cmd]    = v;
               n_cmd++;
            end
            else if (c == "F")
            begin
               n = $fscanf(fd, "%d %d", a, len);
               if (n != 2 || len < 3 || len > `SW_MAX_FRAME_WORDS)
                  ok = 1'b0;
               for (int k = 0; k < len && k < `SW_MAX_FRAME_WORDS; k++)
               begin
                  n = $fscanf(fd, "%h", v);
                  frm_word[n_frm][k] = v;
               end
               frm_src[n_frm]  = a;
               frm_len[n_frm]  = len;
               frm_seen[n_frm] = 1'b0;
               cmd_kind[n_cmd] = "F";
               cmd_a[n_cmd]    = n_frm;
               nibbles += len * 8;
               n_frm++;
               n_cmd++;
            end
            else if (c == "S")
            begin
               cmd_kind[n_cmd] = "S";
               n_cmd++;
            end
            c = $fgetc(fd);
         end
         $fclose(fd);
      end
   endtask

   // single wishbone access, held until ack
   task automatic bus_cycle(logic we, int adr, sw_frame_pkg::word_t wdat,
                            output sw_frame_pkg::word_t rdat);
      @(posedge clk);
      #1;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = $bits(wb_adr_i)'(adr);
      wb_dat_i = wdat;
      @(negedge clk);
      while (!wb_ack_o)
         @(negedge clk);
      rdat = wb_dat_o;
      @(posedge clk);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic table_write(int adr, sw_frame_pkg::word_t data);
      sw_fdb_pkg::fdb_wdata_u u;
      sw_frame_pkg::word_t    unused_rd;
      int                     idx;
      u   = data;
      idx = adr / 2;
      bus_cycle(1'b1, adr, data, unused_rd);
      if (adr % 2 == 1)
      begin
         model[idx].valid      = u.hi.valid;
         model[idx].port       = u.hi.port;
         model[idx].mac[47:32] = u.hi.mac_hi;
      end
      else
         model[idx].mac[31:0] = u.mac_lo;
   endtask

   // lowest valid matching entry decides, miss or own port means discard
   function automatic void route(int id);
      sw_frame_pkg::mac_t mac;
      logic               hit;
      mac         = {frm_word[id][1][15:0], frm_word[id][0]};
      hit         = 1'b0;
      frm_dst[id] = '0;
      for (int k = 0; k < `SW_FDB_ENTRIES; k++)
      begin
         if (!hit && model[k].valid && model[k].mac == mac)
         begin
            hit         = 1'b1;
            frm_dst[id] = model[k].port;
         end
      end
      frm_drop[id] = !hit || frm_dst[id] == sw_frame_pkg::port_t'(frm_src[id]);
   endfunction

   function automatic logic traffic_pending();
      logic busy;
      busy = (drv_busy != '0);
      for (int i = 0; i < N; i++)
      begin
         if (send_q[i].size() != 0)
            busy = 1'b1;
         for (int j = 0; j < N; j++)
            if (exp_q[i][j].size() != 0)
               busy = 1'b1;
      end
      return busy;
   endfunction

   // frames are told apart by the tag in word 2
   task automatic frame_done(int e);
      int id;
      int src;
      int dst;
      int pos;
      int err0;
      err0 = errors;
      id   = -1;
      if (mon_nib[e] != 0)
      begin
         $display("port %0d ended a frame in the middle of a word", e);
         errors++;
      end
      if (got_q[e].size() >= 3)
         for (int f = 0; f < n_frm; f++)
            if (frm_word[f][2] == got_q[e][2])
               id = f;
      if (id < 0)
      begin
         $display("port %0d sent a frame that was never sent to the switch", e);
         errors++;
      end
      else if (frm_drop[id] || frm_seen[id])
      begin
         $display("frame %0d left on port %0d but should not have", id, e);
         errors++;
         frm_seen[id] = 1'b1;
      end
      else
      begin
         frm_seen[id] = 1'b1;
         src = frm_src[id];
         dst = frm_dst[id];
         pos = -1;
         for (int k = exp_q[dst][src].size() - 1; k >= 0; k--)
            if (exp_q[dst][src][k] == id)
               pos = k;
         if (pos > 0)
         begin
            $display("frame %0d from port %0d overtook an earlier frame", id, src);
            errors++;
         end
         if (pos >= 0)
            exp_q[dst][src].delete(pos);
         check_port(sw_frame_pkg::port_t'(e), frm_dst[id], $sformatf("frame %0d egress", id));
         if (got_q[e].size() != frm_len[id])
         begin
            $display("FAIL %0t: frame %0d has %0d words, expected %0d", $time, id,
                     got_q[e].size(), frm_len[id]);
            errors++;
         end
         for (int w = 0; w < frm_len[id] && w < got_q[e].size(); w++)
            check_word(got_q[e][w], frm_word[id][w], $sformatf("frame %0d word %0d", id, w));
      end
      close_test($sformatf("frame %0d out on port %0d", id, e), err0);
      got_q[e].delete();
      mon_nib[e] = 0;
   endtask

   // rebuild words from the nibble streams, low nibble first
   always @(negedge clk)
   begin
      for (int e = 0; e < N; e++)
      begin
         if (tx_en_o[e] === 1'b1)
         begin
            mon_word[e][4*mon_nib[e] +: 4] = tx_nibble_o[e];
            if (mon_nib[e] == 7)
            begin
               got_q[e].push_back(mon_word[e]);
               mon_nib[e] = 0;
            end
            else
               mon_nib[e]++;
         end
         else if (mon_en_q[e])
            frame_done(e);
         mon_en_q[e] = (tx_en_o[e] === 1'b1);
      end
   end

   for (genvar g = 0; g < N; g++)
   begin : g_drv
      logic [3:0] nib;
      logic       dv;
      logic       busy;

      assign rx_nibble_i[g] = nib;
      assign rx_dv_i[g]     = dv;
      assign drv_busy[g]    = busy;

      initial
      begin
         int id;
         int gap;
         nib  = 4'h0;
         dv   = 1'b0;
         busy = 1'b0;
         forever
         begin
            @(posedge clk);
            if (send_q[g].size() != 0)
            begin
               busy = 1'b1;
               id   = send_q[g].pop_front();
               #1;
               for (int w = 0; w < frm_len[id]; w++)
               begin
                  for (int k = 0; k < 8; k++)
                  begin
                     dv  = 1'b1;
                     nib = frm_word[id][w][4*k +: 4];
                     @(posedge clk);
                     #1;
                  end
               end
               dv  = 1'b0;
               nib = 4'h0;
               gap = $urandom_range(4, 1);   // idle cycles between frames
               repeat (gap) @(posedge clk);
               busy = 1'b0;
            end
         end
      end
   end

   initial
   begin
      logic                ok;
      int                  err0;
      int                  id;
      int                  batch [$];
      sw_frame_pkg::word_t rdat;
      void'($urandom(96));
      reset_i  = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      for (int k = 0; k < `SW_FDB_ENTRIES; k++)
         model[k] = '0;
      read_vectors(ok);
      if (!ok)
      begin
         $display("vector file missing or malformed");
         $display("Result: FAILED");
         $finish;
      end
      else
      begin
         limit = nibbles * N + 500;
         repeat (2) @(posedge clk);
         #1;
         reset_i = 1'b0;
         err0    = errors;
         @(negedge clk);
         if (tx_en_o !== '0 || wb_ack_o !== 1'b0)
         begin
            $display("tx_en_o or wb_ack_o active after reset");
            errors++;
         end
         close_test("reset state", err0);
         for (int i = 0; i < n_cmd; i++)
         begin
            err0 = errors;
            case (cmd_kind[i])
               "W": table_write(cmd_a[i], cmd_b[i]);
               "R":
               begin
                  bus_cycle(1'b0, cmd_a[i], '0, rdat);
                  check_word(rdat, cmd_b[i], $sformatf("readback at %h", cmd_a[i]));
                  close_test($sformatf("readback at %h", cmd_a[i]), err0);
               end
               "F":
               begin
                  id = cmd_a[i];
                  route(id);
                  if (!frm_drop[id])
                     exp_q[frm_dst[id]][frm_src[id]].push_back(id);
                  send_q[frm_src[id]].push_back(id);
                  batch.push_back(id);
               end
               default:
               begin
                  do
                     @(negedge clk);
                  while (traffic_pending());
                  // discards drain, stray frames show up
                  repeat (8 * `SW_MAX_FRAME_WORDS) @(negedge clk);
                  foreach (batch[b])
                  begin
                     if (frm_drop[batch[b]])
                     begin
                        err0 = errors;
                        if (frm_seen[batch[b]])
                        begin
                           $display("frame %0d came out although it should be discarded",
                                    batch[b]);
                           errors++;
                        end
                        close_test($sformatf("frame %0d discarded", batch[b]), err0);
                     end
                  end
                  batch.delete();
               end
            endcase
         end
         $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
         if (errors == 0)
            $display("Result: PASSED");
         else
            $display("Result: FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== test/switch_vectors.txt ====
# W adr data = table write, R adr data = readback with expected word, all hex
# F src count words.. = frame from port src, S = wait until the switch is idle
R 0 00000000
R 3 00000000
W 0 00000001
W 1 A000A1A1
W 2 00000002
W 3 C000A1A1
W 4 00000003
W 5 E000A1A1
W 6 00000004
W 7 8000A1A1
W A 00000001
W B E000A1A1
W C 00000009
W D 6000A1A1
R 1 A000A1A1
R 2 00000002
R 7 8000A1A1
R B E000A1A1
R D 6000A1A1
F 0 4 00000002 0000A1A1 5A000001 12345678
S
F 1 3 00000009 0011A1A1 5A000002
F 2 3 00000007 0022A1A1 5A000003
F 1 3 00000001 0011A1A1 5A000004
F 3 5 00000004 0033A1A1 5A000005 CAFE0001 CAFE0002
S
F 0 6 00000003 0000A1A1 5A000006 01010101 02020202 03030303
F 1 8 00000003 0011A1A1 5A000007 11111111 22222222 33333333 44444444 55555555
F 2 4 00000003 0022A1A1 5A000008 89ABCDEF
F 0 3 00000003 0000A1A1 5A000009
S
F 2 16 00000001 0022A1A1 5A00000A 20000003 20000004 20000005 20000006 20000007
       20000008 20000009 2000000A 2000000B 2000000C 2000000D 2000000E 2000000F
F 2 12 00000001 0022A1A1 5A00000B 21000003 21000004 21000005 21000006 21000007
       21000008 21000009 2100000A 2100000B
F 3 16 00000001 0033A1A1 5A00000C 30000003 30000004 30000005 30000006 30000007
       30000008 30000009 3000000A 3000000B 3000000C 3000000D 3000000E 3000000F
S
